// ==== rooth_pkg.sv ====
/* Shared widths, flow codes, result-control codes, load/store sizes
   and opcodes of the RV32 memory-access stage */
`default_nettype none

package rooth_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int CPU_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int FLOW_WIDTH     = 2;
    localparam int WIDTH_RESCTRL  = 2;
    // Word index comes from address bits 9 to 2
    localparam int RAM_WORDS      = 256;

    // ----------------------------------------------------------
    // Pipeline flow codes
    // ----------------------------------------------------------
    localparam logic [FLOW_WIDTH-1:0] FLOW_WORK    = 2'd0;
    localparam logic [FLOW_WIDTH-1:0] FLOW_STOP    = 2'd1;
    localparam logic [FLOW_WIDTH-1:0] FLOW_REFRESH = 2'd2;

    // Result control
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_REG  = 2'd0;
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_MEM  = 2'd1;
    // Bubble marker
    localparam logic [WIDTH_RESCTRL-1:0] RESCTRL_NONE = 2'd3;

    // ----------------------------------------------------------
    // Opcodes and load/store sizes
    // ----------------------------------------------------------
    localparam logic [6:0] INST_TYPE_IL = 7'b0000011;
    localparam logic [6:0] INST_TYPE_S  = 7'b0100011;

    localparam logic [2:0] FUNCT3_B  = 3'b000;
    localparam logic [2:0] FUNCT3_H  = 3'b001;
    localparam logic [2:0] FUNCT3_W  = 3'b010;
    localparam logic [2:0] FUNCT3_BU = 3'b100;
    localparam logic [2:0] FUNCT3_HU = 3'b101;

    // Top address nibble of the instruction-memory region
    localparam logic [3:0] INSTMEM_REGION = 4'h0;

endpackage

`default_nettype wire

// ==== as_fc_reg.sv ====
/* Memory-stage pipeline register with work/stop/refresh control
   and early instruction-memory access flags */
`timescale 1ns/100ps
`default_nettype none

module as_fc_reg (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  [rooth_pkg::FLOW_WIDTH-1:0]      flow_as_i,

    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       inst_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       pc_adder_i,
    input  wire  [rooth_pkg::WIDTH_RESCTRL-1:0]   alu_res_op_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       alu_res_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       rs2_data_i,
    input  wire                                   reg_wr_en_i,
    input  wire  [rooth_pkg::REG_ADDR_WIDTH-1:0]  reg_wr_adder_i,
    input  wire                                   as_no_writing_mem_i,

    output logic [rooth_pkg::CPU_WIDTH-1:0]       inst_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       pc_adder_o,
    output logic [rooth_pkg::WIDTH_RESCTRL-1:0]   alu_res_op_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       alu_res_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       rs2_data_o,
    output logic                                  reg_wr_en_o,
    output logic [rooth_pkg::REG_ADDR_WIDTH-1:0]  reg_wr_adder_o,
    output logic [1:0]                            pr_access_instmem_o
);

    logic mem_ref;
    logic in_instmem;

    // ----------------------------------------------------------
    // Instruction-memory flags decoded from the incoming op
    // ----------------------------------------------------------
    // Store, or register result with the load opcode
    assign mem_ref = (alu_res_op_i == rooth_pkg::RESCTRL_MEM)
                  || ((alu_res_op_i == rooth_pkg::RESCTRL_REG)
                      && (inst_i[6:0] == rooth_pkg::INST_TYPE_IL));

    assign in_instmem = (alu_res_i[rooth_pkg::CPU_WIDTH-1 -: 4] == rooth_pkg::INSTMEM_REGION);

    assign pr_access_instmem_o[0] = mem_ref && in_instmem;
    assign pr_access_instmem_o[1] = mem_ref && in_instmem && as_no_writing_mem_i;

    // ----------------------------------------------------------
    // Control fields
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_res_op_o <= rooth_pkg::RESCTRL_NONE;
            reg_wr_en_o  <= 1'b0;
        end else if (flow_as_i == rooth_pkg::FLOW_WORK) begin
            alu_res_op_o <= alu_res_op_i;
            reg_wr_en_o  <= reg_wr_en_i;
        end else if (flow_as_i != rooth_pkg::FLOW_STOP) begin
            // Refresh or unknown code loads a bubble
            alu_res_op_o <= rooth_pkg::RESCTRL_NONE;
            reg_wr_en_o  <= 1'b0;
        end
    end

    // Payload fields only meaningful next to a valid control field
    always_ff @(posedge clk) begin
        if (flow_as_i == rooth_pkg::FLOW_WORK) begin
            inst_o         <= inst_i;
            pc_adder_o     <= pc_adder_i;
            alu_res_o      <= alu_res_i;
            rs2_data_o     <= rs2_data_i;
            reg_wr_adder_o <= reg_wr_adder_i;
        end
    end

    // The flow controller never issues the spare code
    a_flow_code_legal: assert property (
        @(posedge clk) disable iff (!rst_n) flow_as_i != 2'd3
    );

endmodule

`default_nettype wire

// ==== fc_flow_ctrl.sv ====
/* Flow controller that stalls upstream while a memory access is pending
   and otherwise passes work or a flush refresh */
`timescale 1ns/100ps
`default_nettype none

module fc_flow_ctrl (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   flush_i,
    input  wire  [rooth_pkg::WIDTH_RESCTRL-1:0]   op_res_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       op_inst_i,
    input  wire                                   access_done_i,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]      flow_as_o,
    output logic                                  stall_o
);

    logic mem_op;
    logic done_q;
    logic pending;

    // Held op is a store or a load
    assign mem_op = (op_res_i == rooth_pkg::RESCTRL_MEM)
                 || ((op_res_i == rooth_pkg::RESCTRL_REG)
                     && (op_inst_i[6:0] == rooth_pkg::INST_TYPE_IL));

    // Set once the held op has run its APB transfer and cleared when the register reloads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (access_done_i) begin
            done_q <= 1'b1;
        end else if (flow_as_o != rooth_pkg::FLOW_STOP) begin
            done_q <= 1'b0;
        end
    end

    assign pending = mem_op && !done_q;

    // Pending access wins over flush
    always_comb begin
        if (pending) begin
            flow_as_o = rooth_pkg::FLOW_STOP;
        end else if (flush_i) begin
            flow_as_o = rooth_pkg::FLOW_REFRESH;
        end else begin
            flow_as_o = rooth_pkg::FLOW_WORK;
        end
    end

    assign stall_o = (flow_as_o == rooth_pkg::FLOW_STOP);

    // One APB transfer with a single wait state bounds the stall
    a_stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) stall_o [*4] |=> !stall_o
    );

endmodule

`default_nettype wire

// ==== fc_lsu.sv ====
/* Load/store unit acting as APB master for byte, halfword and word accesses
   with lane alignment, extension and register write-back */
`timescale 1ns/100ps
`default_nettype none

module fc_lsu (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       inst_i,
    input  wire  [rooth_pkg::WIDTH_RESCTRL-1:0]   alu_res_op_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       alu_res_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       rs2_data_i,
    input  wire                                   reg_wr_en_i,
    input  wire  [rooth_pkg::REG_ADDR_WIDTH-1:0]  reg_wr_adder_i,
    input  wire  [rooth_pkg::FLOW_WIDTH-1:0]      flow_as_i,
    input  wire                                   pready_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       prdata_i,

    output logic                                  psel_o,
    output logic                                  penable_o,
    output logic                                  pwrite_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       paddr_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       pwdata_o,
    output logic [3:0]                            pstrb_o,
    output logic                                  access_done_o,
    output logic                                  wb_en_o,
    output logic [rooth_pkg::REG_ADDR_WIDTH-1:0]  wb_addr_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       wb_data_o
);

    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_q;
    logic                             is_store;
    logic                             is_load;
    logic                             new_op;
    logic                             start;
    logic                             access_q;
    logic [2:0]                       funct3;
    logic [1:0]                       byte_off;
    logic [3:0]                       strb_base;
    logic [rooth_pkg::CPU_WIDTH-1:0]  rd_shift;
    logic [rooth_pkg::CPU_WIDTH-1:0]  load_data;

    assign funct3   = inst_i[14:12];
    assign byte_off = alu_res_i[1:0];
    assign is_store = (alu_res_op_i == rooth_pkg::RESCTRL_MEM);
    assign is_load  = (alu_res_op_i == rooth_pkg::RESCTRL_REG)
                   && (inst_i[6:0] == rooth_pkg::INST_TYPE_IL);

    // ----------------------------------------------------------
    // APB sequencing through idle, setup (start) and access (access_q)
    // ----------------------------------------------------------
    // Register reloaded at the last edge when the flow was work
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flow_q <= rooth_pkg::FLOW_WORK;
        end else begin
            flow_q <= flow_as_i;
        end
    end

    assign new_op = (flow_q == rooth_pkg::FLOW_WORK);
    assign start  = (is_store || is_load) && new_op && !access_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            access_q <= 1'b0;
        end else if (start) begin
            access_q <= 1'b1;
        end else if (pready_i) begin
            access_q <= 1'b0;
        end
    end

    assign psel_o        = start || access_q;
    assign penable_o     = access_q;
    assign access_done_o = access_q && pready_i;
    assign pwrite_o      = is_store;
    assign paddr_o       = alu_res_i;

    // ----------------------------------------------------------
    // Store lanes and strobes
    // ----------------------------------------------------------
    always_comb begin
        case (funct3)
            rooth_pkg::FUNCT3_B: strb_base = 4'b0001;
            rooth_pkg::FUNCT3_H: strb_base = 4'b0011;
            default:             strb_base = 4'b1111;
        endcase
    end

    assign pwdata_o = rs2_data_i << {byte_off, 3'b000};
    // Reads carry no strobes
    assign pstrb_o  = is_store ? (strb_base << byte_off) : 4'b0000;

    // ----------------------------------------------------------
    // Load alignment and extension
    // ----------------------------------------------------------
    assign rd_shift = prdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            rooth_pkg::FUNCT3_B:  load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            rooth_pkg::FUNCT3_H:  load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            rooth_pkg::FUNCT3_BU: load_data = {24'b0, rd_shift[7:0]};
            rooth_pkg::FUNCT3_HU: load_data = {16'b0, rd_shift[15:0]};
            rooth_pkg::FUNCT3_W:  load_data = rd_shift;
            default:              load_data = rd_shift;
        endcase
    end

    // Loads write back in the completing cycle and plain results right away
    assign wb_en_o   = reg_wr_en_i
                    && (is_load ? access_done_o : (alu_res_op_i == rooth_pkg::RESCTRL_REG));
    assign wb_addr_o = reg_wr_adder_i;
    assign wb_data_o = is_load ? load_data : alu_res_i;

    // The RAM answers only inside an access phase
    a_pready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) pready_i |-> (psel_o && penable_o)
    );

    a_paddr_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (psel_o && !pready_i) |=> $stable(paddr_o)
    );

    // Decode upstream marks only store opcodes as memory writes
    a_store_opcode: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_store |-> (inst_i[6:0] == rooth_pkg::INST_TYPE_S)
    );

endmodule

`default_nettype wire

// ==== fc_data_ram.sv ====
/* APB data RAM holding a word array with byte strobes and one wait state per access */
`timescale 1ns/100ps
`default_nettype none

module fc_data_ram (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   psel_i,
    input  wire                                   penable_i,
    input  wire                                   pwrite_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       paddr_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       pwdata_i,
    input  wire  [3:0]                            pstrb_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       prdata_o,
    output logic                                  pready_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] mem [rooth_pkg::RAM_WORDS];
    logic [7:0]                      word_idx;
    logic                            in_access;
    logic                            complete;

    assign word_idx  = paddr_i[9:2];
    assign in_access = psel_i && penable_i;
    assign complete  = in_access && pready_o;

    // ----------------------------------------------------------
    // Wait state
    // ----------------------------------------------------------
    // First access cycle waits and the second one completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready_o <= 1'b0;
        end else begin
            pready_o <= in_access && !pready_o;
        end
    end

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (complete && pwrite_i) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb_i[b]) begin
                    mem[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read word lines up with pready
    always_ff @(posedge clk) begin
        if (in_access && !pready_o && !pwrite_i) begin
            prdata_o <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// ==== fc_stage_top.sv ====
/* Memory-access stage joining the pipeline register, flow control, LSU and data RAM */
`timescale 1ns/100ps
`default_nettype none

module fc_stage_top (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   flush_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       inst_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       pc_adder_i,
    input  wire  [rooth_pkg::WIDTH_RESCTRL-1:0]   alu_res_op_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       alu_res_i,
    input  wire  [rooth_pkg::CPU_WIDTH-1:0]       rs2_data_i,
    input  wire                                   reg_wr_en_i,
    input  wire  [rooth_pkg::REG_ADDR_WIDTH-1:0]  reg_wr_adder_i,
    input  wire                                   as_no_writing_mem_i,
    output logic                                  stall_o,
    output logic [1:0]                            pr_access_instmem_o,
    output logic                                  wb_en_o,
    output logic [rooth_pkg::REG_ADDR_WIDTH-1:0]  wb_addr_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]       wb_data_o
);

    logic [rooth_pkg::FLOW_WIDTH-1:0]     flow_as;
    logic [rooth_pkg::CPU_WIDTH-1:0]      inst;
    logic [rooth_pkg::WIDTH_RESCTRL-1:0]  alu_res_op;
    logic [rooth_pkg::CPU_WIDTH-1:0]      alu_res;
    logic [rooth_pkg::CPU_WIDTH-1:0]      rs2_data;
    logic                                 reg_wr_en;
    logic [rooth_pkg::REG_ADDR_WIDTH-1:0] reg_wr_adder;
    logic                                 access_done;

    // APB between LSU and RAM
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [rooth_pkg::CPU_WIDTH-1:0]      paddr;
    logic [rooth_pkg::CPU_WIDTH-1:0]      pwdata;
    logic [3:0]                           pstrb;
    logic [rooth_pkg::CPU_WIDTH-1:0]      prdata;
    logic                                 pready;

    as_fc_reg i_as_fc_reg (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flow_as_i           (flow_as),
        .inst_i              (inst_i),
        .pc_adder_i          (pc_adder_i),
        .alu_res_op_i        (alu_res_op_i),
        .alu_res_i           (alu_res_i),
        .rs2_data_i          (rs2_data_i),
        .reg_wr_en_i         (reg_wr_en_i),
        .reg_wr_adder_i      (reg_wr_adder_i),
        .as_no_writing_mem_i (as_no_writing_mem_i),
        .inst_o              (inst),
        .pc_adder_o          (),
        .alu_res_op_o        (alu_res_op),
        .alu_res_o           (alu_res),
        .rs2_data_o          (rs2_data),
        .reg_wr_en_o         (reg_wr_en),
        .reg_wr_adder_o      (reg_wr_adder),
        .pr_access_instmem_o (pr_access_instmem_o)
    );

    fc_flow_ctrl i_fc_flow_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .op_res_i      (alu_res_op),
        .op_inst_i     (inst),
        .access_done_i (access_done),
        .flow_as_o     (flow_as),
        .stall_o       (stall_o)
    );

    fc_lsu i_fc_lsu (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_i         (inst),
        .alu_res_op_i   (alu_res_op),
        .alu_res_i      (alu_res),
        .rs2_data_i     (rs2_data),
        .reg_wr_en_i    (reg_wr_en),
        .reg_wr_adder_i (reg_wr_adder),
        .flow_as_i      (flow_as),
        .pready_i       (pready),
        .prdata_i       (prdata),
        .psel_o         (psel),
        .penable_o      (penable),
        .pwrite_o       (pwrite),
        .paddr_o        (paddr),
        .pwdata_o       (pwdata),
        .pstrb_o        (pstrb),
        .access_done_o  (access_done),
        .wb_en_o        (wb_en_o),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o)
    );

    fc_data_ram i_fc_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

endmodule

`default_nettype wire

// ==== tb_fc_stage.sv ====
/* Testbench for the memory-access stage that checks a table of ALU, store, load
   and flush operations against a byte-level memory model */
`timescale 1ns/100ps
`default_nettype none

module tb_fc_stage;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ROWS   = 32;
    localparam int K_ALU      = 0;
    localparam int K_ST       = 1;
    localparam int K_LD       = 2;
    localparam int K_FL       = 3;
    localparam logic [6:0] OPC_ALU = 7'b0110011;
    localparam logic [2:0] F_B  = rooth_pkg::FUNCT3_B;
    localparam logic [2:0] F_H  = rooth_pkg::FUNCT3_H;
    localparam logic [2:0] F_W  = rooth_pkg::FUNCT3_W;
    localparam logic [2:0] F_BU = rooth_pkg::FUNCT3_BU;
    localparam logic [2:0] F_HU = rooth_pkg::FUNCT3_HU;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic [31:0] inst_i;
    logic [31:0] pc_adder_i;
    logic [1:0]  alu_res_op_i;
    logic [31:0] alu_res_i;
    logic [31:0] rs2_data_i;
    logic        reg_wr_en_i;
    logic [4:0]  reg_wr_adder_i;
    logic        as_no_writing_mem_i;
    logic        stall_o;
    logic [1:0]  pr_access_instmem_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    // Stimulus table with one entry per row
    int          row_kind  [MAX_ROWS];
    logic [2:0]  row_f3    [MAX_ROWS];
    logic [31:0] row_addr  [MAX_ROWS];
    logic [31:0] row_data  [MAX_ROWS];
    logic        row_rnd   [MAX_ROWS];
    logic [4:0]  row_rd    [MAX_ROWS];
    logic        row_wr_en [MAX_ROWS];
    logic        row_nowr  [MAX_ROWS];
    logic [1:0]  row_flags [MAX_ROWS];
    int          n_rows;

    logic [31:0] model_mem [rooth_pkg::RAM_WORDS];
    logic [31:0] lfsr;
    int          pass_count;
    int          fail_count;
    int          row_errors;
    string       kind_names [4] = '{"alu", "store", "load", "flush"};

    fc_stage_top i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush_i             (flush_i),
        .inst_i              (inst_i),
        .pc_adder_i          (pc_adder_i),
        .alu_res_op_i        (alu_res_op_i),
        .alu_res_i           (alu_res_i),
        .rs2_data_i          (rs2_data_i),
        .reg_wr_en_i         (reg_wr_en_i),
        .reg_wr_adder_i      (reg_wr_adder_i),
        .as_no_writing_mem_i (as_no_writing_mem_i),
        .stall_o             (stall_o),
        .pr_access_instmem_o (pr_access_instmem_o),
        .wb_en_o             (wb_en_o),
        .wb_addr_o           (wb_addr_o),
        .wb_data_o           (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------
    // Random data and memory model
    // ----------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    // Low bytes of the data land in consecutive lanes from the address offset
    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data);
        int nbytes;
        int lane;
        nbytes = (f3 == F_B) ? 1 : ((f3 == F_H) ? 2 : 4);
        for (int i = 0; i < nbytes; i++) begin
            lane = int'(addr[1:0]) + i;
            model_mem[addr[9:2]][8*lane +: 8] = data[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[addr[9:2]];
        b = w[8*int'(addr[1:0]) +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (f3)
            F_B:     model_load = {{24{b[7]}}, b};
            F_BU:    model_load = {24'b0, b};
            F_H:     model_load = {{16{h[15]}}, h};
            F_HU:    model_load = {16'b0, h};
            default: model_load = w;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL at time %0t: %s is %h, expected %h", $time, what, got, exp);
        row_errors++;
    endtask

    // ----------------------------------------------------------
    // Table
    // ----------------------------------------------------------
    task automatic add_row(input int kind, input logic [2:0] f3, input logic [31:0] addr,
                           input logic [31:0] data, input logic rnd, input logic [4:0] rd,
                           input logic wr_en, input logic nowr, input logic [1:0] flags);
        row_kind[n_rows]  = kind;
        row_f3[n_rows]    = f3;
        row_addr[n_rows]  = addr;
        row_data[n_rows]  = data;
        row_rnd[n_rows]   = rnd;
        row_rd[n_rows]    = rd;
        row_wr_en[n_rows] = wr_en;
        row_nowr[n_rows]  = nowr;
        row_flags[n_rows] = flags;
        n_rows++;
    endtask

    task automatic build_table();
        //      kind   f3    address        data           rnd   rd     wr    nowr  flags
        add_row(K_ALU, F_W,  32'h0,         32'h0,         1'b1, 5'd5,  1'b1, 1'b0, 2'b00);
        add_row(K_ALU, F_W,  32'h0,         32'h0000_0044, 1'b0, 5'd6,  1'b0, 1'b1, 2'b00);
        add_row(K_ST,  F_W,  32'h40,        32'h0,         1'b1, 5'd0,  1'b0, 1'b0, 2'b01);
        add_row(K_LD,  F_W,  32'h40,        32'h0,         1'b0, 5'd7,  1'b1, 1'b1, 2'b11);
        // Sub-word merges outside the instruction region
        add_row(K_ST,  F_W,  32'h1000_0080, 32'h8070_6050, 1'b0, 5'd0,  1'b0, 1'b1, 2'b00);
        add_row(K_ST,  F_B,  32'h1000_0081, 32'h0000_00a5, 1'b0, 5'd0,  1'b0, 1'b0, 2'b00);
        add_row(K_ST,  F_H,  32'h1000_0082, 32'h0000_9abc, 1'b0, 5'd0,  1'b0, 1'b0, 2'b00);
        add_row(K_LD,  F_B,  32'h1000_0081, 32'h0,         1'b0, 5'd8,  1'b1, 1'b0, 2'b00);
        add_row(K_LD,  F_BU, 32'h1000_0081, 32'h0,         1'b0, 5'd9,  1'b1, 1'b0, 2'b00);
        add_row(K_LD,  F_H,  32'h1000_0082, 32'h0,         1'b0, 5'd10, 1'b1, 1'b0, 2'b00);
        add_row(K_LD,  F_HU, 32'h1000_0082, 32'h0,         1'b0, 5'd11, 1'b1, 1'b0, 2'b00);
        add_row(K_LD,  F_W,  32'h1000_0080, 32'h0,         1'b0, 5'd12, 1'b1, 1'b0, 2'b00);
        // Remaining byte offsets and the low halfword
        add_row(K_ST,  F_W,  32'hc0,        32'h0,         1'b1, 5'd0,  1'b0, 1'b0, 2'b01);
        add_row(K_ST,  F_B,  32'hc0,        32'h0000_007f, 1'b0, 5'd0,  1'b0, 1'b0, 2'b01);
        add_row(K_ST,  F_B,  32'hc2,        32'h0,         1'b1, 5'd0,  1'b0, 1'b1, 2'b11);
        add_row(K_ST,  F_B,  32'hc3,        32'h0000_0080, 1'b0, 5'd0,  1'b0, 1'b0, 2'b01);
        add_row(K_LD,  F_B,  32'hc3,        32'h0,         1'b0, 5'd13, 1'b1, 1'b0, 2'b01);
        add_row(K_LD,  F_BU, 32'hc2,        32'h0,         1'b0, 5'd14, 1'b1, 1'b1, 2'b11);
        add_row(K_LD,  F_H,  32'hc0,        32'h0,         1'b0, 5'd15, 1'b1, 1'b0, 2'b01);
        add_row(K_ST,  F_H,  32'hc0,        32'h0000_f00d, 1'b0, 5'd0,  1'b0, 1'b0, 2'b01);
        add_row(K_LD,  F_W,  32'hc0,        32'h0,         1'b0, 5'd16, 1'b1, 1'b0, 2'b01);
        // Flushed store never reaches the RAM
        add_row(K_FL,  F_W,  32'hc0,        32'hdead_beef, 1'b0, 5'd0,  1'b0, 1'b1, 2'b11);
        add_row(K_LD,  F_W,  32'hc0,        32'h0,         1'b0, 5'd17, 1'b1, 1'b0, 2'b01);
        add_row(K_ALU, F_W,  32'h0,         32'h0,         1'b1, 5'd31, 1'b1, 1'b0, 2'b00);
    endtask

    // ----------------------------------------------------------
    // Drive one row, check its flags, follow the stall and check the write-back
    // ----------------------------------------------------------
    task automatic run_row(input int r);
        int          kind;
        int          stall_cycles;
        int          wb_count;
        int          exp_stall;
        int          exp_wb;
        logic [6:0]  opcode;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic [31:0] wb_data;
        logic [4:0]  wb_addr;
        kind         = row_kind[r];
        data         = row_rnd[r] ? random_word() : row_data[r];
        row_errors   = 0;
        stall_cycles = 0;
        wb_count     = 0;
        wb_data      = '0;
        wb_addr      = '0;
        while (stall_o) @(negedge clk);
        case (kind)
            K_ALU:   opcode = OPC_ALU;
            K_LD:    opcode = rooth_pkg::INST_TYPE_IL;
            default: opcode = rooth_pkg::INST_TYPE_S;
        endcase
        flush_i             = (kind == K_FL);
        inst_i              = {17'b0, row_f3[r], 5'b0, opcode};
        pc_adder_i          = 32'h100 + (r << 2);
        alu_res_op_i        = (kind == K_ST || kind == K_FL) ? rooth_pkg::RESCTRL_MEM
                                                             : rooth_pkg::RESCTRL_REG;
        alu_res_i           = (kind == K_ALU) ? data : row_addr[r];
        rs2_data_i          = (kind == K_ALU) ? 32'h0 : data;
        reg_wr_en_i         = row_wr_en[r];
        reg_wr_adder_i      = row_rd[r];
        as_no_writing_mem_i = row_nowr[r];
        #(CLK_PERIOD / 4);
        if (pr_access_instmem_o !== row_flags[r]) begin
            report_mismatch("instmem flags", 32'(pr_access_instmem_o), 32'(row_flags[r]));
        end
        @(negedge clk);
        forever begin
            if (wb_en_o) begin
                wb_count++;
                wb_data = wb_data_o;
                wb_addr = wb_addr_o;
            end
            if (!stall_o) break;
            stall_cycles++;
            @(negedge clk);
        end
        exp_stall = (kind == K_ST || kind == K_LD) ? 3 : 0;
        exp_wb    = (kind != K_FL && row_wr_en[r]) ? 1 : 0;
        exp_data  = (kind == K_LD) ? model_load(row_f3[r], row_addr[r]) : data;
        if (stall_cycles != exp_stall) begin
            report_mismatch("stall cycles", stall_cycles, exp_stall);
        end
        if (wb_count != exp_wb) begin
            report_mismatch("write-back count", wb_count, exp_wb);
        end
        if (exp_wb == 1 && wb_data !== exp_data) begin
            report_mismatch("write-back data", wb_data, exp_data);
        end
        if (exp_wb == 1 && wb_addr !== row_rd[r]) begin
            report_mismatch("write-back register", 32'(wb_addr), 32'(row_rd[r]));
        end
        if (kind == K_ST) begin
            model_store(row_f3[r], row_addr[r], data);
        end
        if (row_errors == 0) begin
            pass_count++;
            $display("row %0d %s: ok", r, kind_names[kind]);
        end else begin
            fail_count++;
            $display("row %0d %s: %0d mismatches", r, kind_names[kind], row_errors);
        end
    endtask

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        flush_i             = 1'b0;
        inst_i              = '0;
        pc_adder_i          = '0;
        alu_res_op_i        = rooth_pkg::RESCTRL_NONE;
        alu_res_i           = '0;
        rs2_data_i          = '0;
        reg_wr_en_i         = 1'b0;
        reg_wr_adder_i      = '0;
        as_no_writing_mem_i = 1'b0;
        lfsr                = 32'h164;
        n_rows              = 0;
        pass_count          = 0;
        fail_count          = 0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (stall_o || wb_en_o) begin
            $display("Stall or write-back active right after reset");
            fail_count++;
        end
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((n_rows * 10 + 100) * CLK_PERIOD);
        $display("Timeout: the stage did not get through the %0d table rows", n_rows);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rooth_pkg.sv
as_fc_reg.sv
fc_flow_ctrl.sv
fc_lsu.sv
fc_data_ram.sv
fc_stage_top.sv
tb_fc_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory-stage testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_fc_stage \
    && ./obj_dir/Vtb_fc_stage | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
